// File: nes_cart_pkg.sv
/*
 * Shared constants and types for the cartridge loading path.
 * Modules refer to these by scoped name only.
 */
package nes_cart_pkg;

	// Memory map
	localparam int addr_w = 22;                 // Default memory address width
	localparam int chr_base_bit = addr_w - 1;   // Top bit selects the CHR half

	// Page sizes as log2 of bytes
	localparam int prg_page_shift = 14;         // 16 KiB PRG pages
	localparam int chr_page_shift = 13;         // 8 KiB CHR pages

	// "NES" followed by EOF, header bytes 0 to 3
	localparam logic [31:0] ines_magic = 32'h4E45_531A;

	typedef enum logic [2:0] {
		ld_header,
		ld_prg,
		ld_chr,
		ld_error,
		ld_done
	} loader_state_t;

	//////////////////////////////////////////////////////////////////////
	// Mapper flags word as seen by the console, MSB first
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0] zero;        // Reserved, always 0
		logic       has_saves;   // Battery backed RAM
		logic [7:0] submapper;   // NES 2.0 byte 8
		logic       four_screen;
		logic       chr_ram;     // No CHR ROM in the file
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

// File: mem_bus_if.sv
/*
 * One memory request bus between the write buffer and the arbiter.
 * Plain strobes, no handshake.
 */
interface mem_bus_if #(
	parameter int addr_w = nes_cart_pkg::addr_w
);

	logic [addr_w-1:0] addr;
	logic [7:0]        wdata;
	logic              write;   // One-cycle write strobe
	logic              read;

	modport requester (
		output addr,
		output wdata,
		output write,
		output read
	);

	modport arbiter (
		input addr,
		input wdata,
		input write,
		input read
	);

endinterface

// File: game_loader.sv
/*
 * iNES file parser. Takes the download stream byte by byte, checks the
 * header, places PRG from address 0 and CHR in the upper half, and
 * forms the mapper flags word from the header.
 */
module game_loader #(
	parameter int addr_w = nes_cart_pkg::addr_w
) (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        dl_wr,
	input  logic [7:0]                  dl_data,
	input  logic                        invert_mirroring,
	output logic [addr_w-1:0]           ld_addr,
	output logic [7:0]                  ld_data,
	output logic                        ld_write,
	output logic                        busy,
	output logic                        done,
	output logic                        error,
	output nes_cart_pkg::mapper_flags_t flags
);

	// CHR marker bit follows the top of the address
	localparam int chr_bit = nes_cart_pkg::chr_base_bit + addr_w - nes_cart_pkg::addr_w;
	localparam logic [addr_w-1:0] chr_base = addr_w'(1) << chr_bit;
	// Wide enough for 255 PRG pages
	localparam int cnt_w = 8 + nes_cart_pkg::prg_page_shift;

	nes_cart_pkg::loader_state_t state;

	logic [7:0]       hdr [16];     // Raw iNES header
	logic [3:0]       ctr;          // Header byte index
	logic [cnt_w-1:0] bytes_left;
	logic [7:0]       prg_pages;
	logic [7:0]       chr_pages;
	logic             magic_ok;
	logic             is_nes20;
	logic             is_dirty;

	// Smallest k with pages <= 2**k, capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= 9'(1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];
	assign magic_ok  = ({hdr[0], hdr[1], hdr[2], hdr[3]} == nes_cart_pkg::ines_magic);
	assign is_nes20  = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail of the header
	assign is_dirty = !is_nes20 &&
		((hdr[9][7:1] != 7'd0) ||
		 ((hdr[10] | hdr[11] | hdr[12] | hdr[13] | hdr[14] | hdr[15]) != 8'd0));

	// Payload bytes go straight through, header bytes never reach memory
	assign ld_data  = dl_data;
	assign ld_write = dl_wr && (bytes_left != '0) && (state == nes_cart_pkg::ld_prg ||
		state == nes_cart_pkg::ld_chr);

	always_ff @(posedge clk) begin
		if (state == nes_cart_pkg::ld_header && dl_wr)
			hdr[ctr] <= dl_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Load sequencer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= nes_cart_pkg::ld_header;
			ctr        <= 4'd0;
			bytes_left <= '0;
			ld_addr    <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				nes_cart_pkg::ld_header: begin
					if (dl_wr) begin
						ctr <= ctr + 1'b1;
						if (ctr == 4'd15) begin
							busy <= 1'b1;
							// No trainer support
							if (magic_ok && !hdr[6][2]) begin
								state      <= nes_cart_pkg::ld_prg;
								ld_addr    <= '0;
								bytes_left <= cnt_w'(prg_pages) << nes_cart_pkg::prg_page_shift;
							end else begin
								state <= nes_cart_pkg::ld_error;
							end
						end
					end
				end
				nes_cart_pkg::ld_prg: begin
					if (bytes_left != '0) begin
						if (dl_wr) begin
							bytes_left <= bytes_left - 1'b1;
							ld_addr    <= ld_addr + 1'b1;
						end
					end else begin
						state      <= nes_cart_pkg::ld_chr;
						ld_addr    <= chr_base;
						bytes_left <= cnt_w'(chr_pages) << nes_cart_pkg::chr_page_shift;
					end
				end
				nes_cart_pkg::ld_chr: begin
					if (bytes_left != '0) begin
						if (dl_wr) begin
							bytes_left <= bytes_left - 1'b1;
							ld_addr    <= ld_addr + 1'b1;
						end
					end else begin
						state <= nes_cart_pkg::ld_done;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end
				nes_cart_pkg::ld_error: begin
					state <= nes_cart_pkg::ld_done;
					error <= 1'b1;
					done  <= 1'b1;
					busy  <= 1'b0;
				end
				nes_cart_pkg::ld_done: ;   // Hold until the next reset
				default: state <= nes_cart_pkg::ld_header;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Mapper flags from the stored header
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		flags             = '0;
		flags.has_saves   = hdr[6][1];
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.chr_ram     = (chr_pages == 8'd0);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(chr_pages);
		flags.prg_size    = size_code(prg_pages);
		// Upper nibble unreliable on dirty headers
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

// File: loader_write_buffer.sv
/*
 * One-byte write buffer between the loader and the memory port.
 * Waits for a memory slot and stalls the download source meanwhile.
 */
module loader_write_buffer #(
	parameter int addr_w = nes_cart_pkg::addr_w
) (
	input  logic              clk,
	input  logic              reset_nes,
	input  logic [addr_w-1:0] ld_addr,
	input  logic [7:0]        ld_data,
	input  logic              ld_write,
	input  logic              mem_slot,
	output logic              dl_wait,
	mem_bus_if.requester      req
);

	logic [addr_w-1:0] addr_q;
	logic [7:0]        data_q;
	logic              pending;   // Byte held, not yet written

	always_ff @(posedge clk) begin
		if (ld_write) begin
			addr_q <= ld_addr;
			data_q <= ld_data;
		end
	end

	// Wait drops one slot after the write has gone out
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending <= 1'b0;
			dl_wait <= 1'b0;
		end else if (ld_write) begin
			pending <= 1'b1;
			dl_wait <= 1'b1;
		end else if (mem_slot) begin
			if (pending)
				pending <= 1'b0;
			else
				dl_wait <= 1'b0;
		end
	end

	assign req.addr  = addr_q;
	assign req.wdata = data_q;
	assign req.write = pending && mem_slot;   // Exactly one cycle per byte
	assign req.read  = 1'b0;                  // Loader never reads back

endmodule

// File: mem_arbiter.sv
/*
 * Shares one memory port between the loader path and the console CPU.
 * The loader side wins for the whole download, console requests are masked.
 */
module mem_arbiter #(
	parameter int addr_w = nes_cart_pkg::addr_w
) (
	input  logic              loader_owns,
	mem_bus_if.arbiter        req,
	input  logic [addr_w-1:0] cpu_addr,
	input  logic              cpu_read,
	input  logic              cpu_write,
	input  logic [7:0]        cpu_wdata,
	input  logic [7:0]        mem_rdata,
	output logic [addr_w-1:0] mem_addr,
	output logic              mem_read,
	output logic              mem_we,
	output logic [7:0]        mem_wdata,
	output logic [7:0]        cpu_rdata
);

	//////////////////////////////////////////////////////////////////////
	// Request select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (loader_owns) begin
			// Console dropped so a half-loaded image stays intact
			mem_addr  = req.addr;
			mem_wdata = req.wdata;
			mem_we    = req.write;
			mem_read  = req.read;
		end else begin
			mem_addr  = cpu_addr;
			mem_wdata = cpu_wdata;
			mem_we    = cpu_write;
			mem_read  = cpu_read;
		end
	end

	// Read data only ever belongs to the console
	assign cpu_rdata = mem_rdata;

endmodule

// File: nes_cart_loader.sv
/*
 * Cartridge loading path top level. Connects the iNES loader, its write
 * buffer and the memory arbiter to the download, console and memory ports.
 */
module nes_cart_loader #(
	parameter int addr_w = nes_cart_pkg::addr_w
) (
	input  logic              clk,
	input  logic              reset_nes,

	// Download port
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [7:0]        dl_data,
	output logic              dl_wait,
	input  logic              invert_mirroring,

	// Console port
	input  logic [addr_w-1:0] cpu_addr,
	input  logic              cpu_read,
	input  logic              cpu_write,
	input  logic [7:0]        cpu_wdata,
	output logic [7:0]        cpu_rdata,

	// Shared memory port
	input  logic              mem_slot,
	output logic [addr_w-1:0] mem_addr,
	output logic              mem_read,
	output logic              mem_we,
	output logic [7:0]        mem_wdata,
	input  logic [7:0]        mem_rdata,

	// Status
	output logic [31:0]       mapper_flags,
	output logic              loader_busy,
	output logic              loader_done,
	output logic              loader_error
);

	logic [addr_w-1:0]           ld_addr;
	logic [7:0]                  ld_data;
	logic                        ld_write;
	logic                        loader_owns;
	nes_cart_pkg::mapper_flags_t ld_flags;
	nes_cart_pkg::mapper_flags_t flags_q;   // Published flags

	mem_bus_if #(.addr_w(addr_w)) ld_bus ();

	game_loader #(.addr_w(addr_w)) u_game_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_wr            (dl_wr),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.ld_addr          (ld_addr),
		.ld_data          (ld_data),
		.ld_write         (ld_write),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error),
		.flags            (ld_flags)
	);

	loader_write_buffer #(.addr_w(addr_w)) u_loader_write_buffer (
		.clk       (clk),
		.reset_nes (reset_nes),
		.ld_addr   (ld_addr),
		.ld_data   (ld_data),
		.ld_write  (ld_write),
		.mem_slot  (mem_slot),
		.dl_wait   (dl_wait),
		.req       (ld_bus.requester)
	);

	// Loader keeps the port until parsing is finished
	assign loader_owns = dl_active || loader_busy;

	mem_arbiter #(.addr_w(addr_w)) u_mem_arbiter (
		.loader_owns (loader_owns),
		.req         (ld_bus.arbiter),
		.cpu_addr    (cpu_addr),
		.cpu_read    (cpu_read),
		.cpu_write   (cpu_write),
		.cpu_wdata   (cpu_wdata),
		.mem_rdata   (mem_rdata),
		.mem_addr    (mem_addr),
		.mem_read    (mem_read),
		.mem_we      (mem_we),
		.mem_wdata   (mem_wdata),
		.cpu_rdata   (cpu_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// Flags publish
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes)
			flags_q <= '0;
		else if (loader_done)
			flags_q <= ld_flags;
	end

	// Console sees no mapper while a file is coming in
	assign mapper_flags = dl_active ? 32'd0 : flags_q;

endmodule

// File: tb_nes_cart_loader.sv
/*
 * Testbench for the cartridge loading path. Streams a table of iNES files
 * through the download port, records every memory write in a model and
 * checks placement, mapper flags, error handling and console masking.
 */
module tb_nes_cart_loader;

	localparam int addr_w        = nes_cart_pkg::addr_w;
	localparam int period        = 100;
	localparam int n_cases       = 6;
	localparam int chr_base      = 1 << (addr_w - 1);
	localparam int console_probe = 'h15_5555;   // Outside every PRG and CHR range

	logic              clk;
	logic              reset_nes;
	logic              dl_active;
	logic              dl_wr;
	logic [7:0]        dl_data;
	logic              dl_wait;
	logic              invert_mirroring;
	logic [addr_w-1:0] cpu_addr;
	logic              cpu_read;
	logic              cpu_write;
	logic [7:0]        cpu_wdata;
	logic [7:0]        cpu_rdata;
	logic              mem_slot;
	logic [addr_w-1:0] mem_addr;
	logic              mem_read;
	logic              mem_we;
	logic [7:0]        mem_wdata;
	logic [7:0]        mem_rdata;
	logic [31:0]       mapper_flags;
	logic              loader_busy;
	logic              loader_done;
	logic              loader_error;

	// ROM case table
	string        case_name  [n_cases];
	logic [127:0] case_hdr   [n_cases];   // Byte 0 in the top bits
	logic         case_inv   [n_cases];
	logic [31:0]  case_flags [n_cases];
	logic         case_err   [n_cases];
	bit           table_ready = 1'b0;

	logic [7:0]  mem_model [int];   // Written bytes by address
	int          write_count;
	int          dup_writes;
	int          stall_cycles;
	int          slot_ctr;
	int          checks = 0;
	int          errors = 0;
	logic [31:0] lcg_state;

	nes_cart_loader #(.addr_w(addr_w)) u_nes_cart_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_active        (dl_active),
		.dl_wr            (dl_wr),
		.dl_data          (dl_data),
		.dl_wait          (dl_wait),
		.invert_mirroring (invert_mirroring),
		.cpu_addr         (cpu_addr),
		.cpu_read         (cpu_read),
		.cpu_write        (cpu_write),
		.cpu_wdata        (cpu_wdata),
		.cpu_rdata        (cpu_rdata),
		.mem_slot         (mem_slot),
		.mem_addr         (mem_addr),
		.mem_read         (mem_read),
		.mem_we           (mem_we),
		.mem_wdata        (mem_wdata),
		.mem_rdata        (mem_rdata),
		.mapper_flags     (mapper_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Memory write slot every 4th cycle
	initial begin
		mem_slot = 1'b0;
		slot_ctr = 0;
		forever begin
			@(posedge clk);
			#10;
			slot_ctr = slot_ctr + 1;
			mem_slot = (slot_ctr % 4 == 0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!reset_nes && mem_we) begin
			if (mem_model.exists(int'(mem_addr)))
				dup_writes = dup_writes + 1;
			mem_model[int'(mem_addr)] = mem_wdata;
			write_count = write_count + 1;
		end
		if (dl_active && mem_read) begin
			errors = errors + 1;
			$display("Console read reached the memory port during a download");
		end
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Field layout of the mapper flags word, MSB first
	function automatic logic [31:0] make_flags(input logic saves, input logic [7:0] sub,
		input logic four, input logic chr_ram, input logic mirr, input logic [2:0] chr_size,
		input logic [2:0] prg_size, input logic [7:0] mapper);
		return {6'b0, saves, sub, four, chr_ram, mirr, chr_size, prg_size, mapper};
	endfunction

	function automatic logic [7:0] hdr_byte(input int idx, input int k);
		return case_hdr[idx][127 - 8 * k -: 8];
	endfunction

	// Header plus payload, or header plus junk for rejected files
	function automatic int stream_length(input int idx);
		if (case_err[idx])
			return 16 + 8;
		return 16 + (int'(hdr_byte(idx, 4)) << nes_cart_pkg::prg_page_shift) +
			(int'(hdr_byte(idx, 5)) << nes_cart_pkg::chr_page_shift);
	endfunction

	task automatic fill_table();
		case_name[0] = "clean_ines1";
		case_hdr[0]  = {32'h4E45_531A, 8'h01, 8'h01, 8'h41, 8'h10, 64'h0};
		case_inv[0]  = 1'b0;
		case_flags[0] = make_flags(1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd0, 3'd0, 8'h14);
		case_err[0]  = 1'b0;
		// "D" junk in byte 12 clears the upper mapper nibble
		case_name[1] = "dirty_header";
		case_hdr[1]  = {32'h4E45_531A, 8'h01, 8'h00, 8'h18, 8'h20,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h44, 8'h00, 8'h00, 8'h00};
		case_inv[1]  = 1'b1;
		case_flags[1] = make_flags(1'b0, 8'h00, 1'b1, 1'b1, 1'b1, 3'd0, 3'd0, 8'h01);
		case_err[1]  = 1'b0;
		case_name[2] = "nes20_submapper";
		case_hdr[2]  = {32'h4E45_531A, 8'h01, 8'h01, 8'h12, 8'h48,
			8'h35, 8'h00, 8'h07, 8'h00, 32'h0};
		case_inv[2]  = 1'b0;
		case_flags[2] = make_flags(1'b1, 8'h35, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h41);
		case_err[2]  = 1'b0;
		// Byte 9 bit 0 alone keeps the header clean
		case_name[3] = "chr_ram_2prg";
		case_hdr[3]  = {32'h4E45_531A, 8'h02, 8'h00, 8'h21, 8'h30, 8'h00, 8'h01, 48'h0};
		case_inv[3]  = 1'b1;
		case_flags[3] = make_flags(1'b0, 8'h00, 1'b0, 1'b1, 1'b0, 3'd0, 3'd1, 8'h32);
		case_err[3]  = 1'b0;
		case_name[4] = "bad_magic";
		case_hdr[4]  = {32'h4E45_5300, 8'h01, 8'h01, 8'h00, 8'h00, 64'h0};
		case_inv[4]  = 1'b0;
		case_flags[4] = 32'h0;
		case_err[4]  = 1'b1;
		case_name[5] = "trainer_set";
		case_hdr[5]  = {32'h4E45_531A, 8'h01, 8'h01, 8'h04, 8'h00, 64'h0};
		case_inv[5]  = 1'b0;
		case_flags[5] = 32'h0;
		case_err[5]  = 1'b1;
	endtask

	task automatic check_equal(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
		end
	endtask

	task automatic verify_byte(input string test, input int addr, input logic [7:0] expected);
		checks = checks + 1;
		if (!mem_model.exists(addr)) begin
			errors = errors + 1;
			$display("%s: no write reached address %h", test, addr);
		end else if (mem_model[addr] !== expected) begin
			errors = errors + 1;
			$display("MISMATCH %s addr %h: expected %h, actual %h",
				test, addr, expected, mem_model[addr]);
		end
	endtask

	task automatic apply_reset();
		reset_nes = 1'b1;
		repeat (4) begin
			@(posedge clk);
			#10;
		end
		reset_nes = 1'b0;
	endtask

	task automatic check_reset_state(input string test);
		check_equal(test, "loader_busy", 32'd0, loader_busy);
		check_equal(test, "loader_done", 32'd0, loader_done);
		check_equal(test, "loader_error", 32'd0, loader_error);
		check_equal(test, "dl_wait", 32'd0, dl_wait);
		check_equal(test, "mem_we", 32'd0, mem_we);
		check_equal(test, "mapper_flags", 32'd0, mapper_flags);
	endtask

	// Source honours dl_wait before every strobe
	task automatic send_byte(input logic [7:0] value);
		while (dl_wait) begin
			stall_cycles = stall_cycles + 1;
			@(posedge clk);
			#10;
		end
		dl_data = value;
		dl_wr   = 1'b1;
		@(posedge clk);
		#10;
		dl_wr = 1'b0;
	endtask

	task automatic wait_load_end(input string test);
		int n;
		n = 0;
		while (!(loader_done && !dl_wait) && n < 64) begin
			@(posedge clk);
			#10;
			n = n + 1;
		end
		checks = checks + 1;
		if (!(loader_done && !dl_wait)) begin
			errors = errors + 1;
			$display("%s: load did not finish within 64 cycles of the last byte", test);
		end
	endtask

	task automatic console_idle_test();
		mem_model.delete();
		write_count = 0;
		cpu_addr  = addr_w'('h01_2345);
		cpu_wdata = 8'h5a;
		cpu_write = 1'b1;
		#40;
		check_equal("console_idle", "mem_we", 32'd1, mem_we);
		check_equal("console_idle", "mem_addr", 32'h01_2345, mem_addr);
		check_equal("console_idle", "mem_wdata", 32'h5a, mem_wdata);
		@(posedge clk);
		#10;
		cpu_write = 1'b0;
		check_equal("console_idle", "write count", 32'd1, write_count);
		verify_byte("console_idle", 'h01_2345, 8'h5a);
		cpu_addr  = addr_w'('h2a_bcde);
		cpu_read  = 1'b1;
		mem_rdata = 8'hc3;
		#40;
		check_equal("console_idle", "mem_read", 32'd1, mem_read);
		check_equal("console_idle", "read addr", 32'h2a_bcde, mem_addr);
		check_equal("console_idle", "cpu_rdata", 32'hc3, cpu_rdata);
		@(posedge clk);
		#10;
		cpu_read  = 1'b0;
		mem_rdata = 8'h00;
	endtask

	//////////////////////////////////////////////////////////////////////
	// One table entry from reset to memory check
	//////////////////////////////////////////////////////////////////////
	task automatic run_case(input int idx);
		int          prg_bytes;
		int          chr_bytes;
		int          expect_writes;
		logic [31:0] seed_start;
		logic [31:0] s;
		prg_bytes = case_err[idx] ? 0 : int'(hdr_byte(idx, 4)) << nes_cart_pkg::prg_page_shift;
		chr_bytes = case_err[idx] ? 0 : int'(hdr_byte(idx, 5)) << nes_cart_pkg::chr_page_shift;
		expect_writes = prg_bytes + chr_bytes;
		invert_mirroring = case_inv[idx];
		apply_reset();
		check_reset_state(case_name[idx]);
		mem_model.delete();
		write_count  = 0;
		dup_writes   = 0;
		stall_cycles = 0;
		// Console keeps hammering the port for the whole download
		dl_active = 1'b1;
		cpu_addr  = addr_w'(console_probe);
		cpu_wdata = 8'hee;
		cpu_write = 1'b1;
		cpu_read  = 1'b1;
		for (int k = 0; k < 16; k++)
			send_byte(hdr_byte(idx, k));
		check_equal(case_name[idx], "busy after header", 32'd1, loader_busy);
		seed_start = lcg_state;
		for (int k = 0; k < stream_length(idx) - 16; k++) begin
			lcg_state = lcg_step(lcg_state);
			send_byte(lcg_state[23:16]);
		end
		wait_load_end(case_name[idx]);
		check_equal(case_name[idx], "loader_error", 32'(case_err[idx]), loader_error);
		check_equal(case_name[idx], "flags during download", 32'd0, mapper_flags);
		cpu_write = 1'b0;
		cpu_read  = 1'b0;
		dl_active = 1'b0;
		@(posedge clk);
		#10;
		if (!case_err[idx])
			check_equal(case_name[idx], "mapper_flags", case_flags[idx], mapper_flags);
		check_equal(case_name[idx], "write count", 32'(expect_writes), write_count);
		check_equal(case_name[idx], "repeated writes", 32'd0, dup_writes);
		checks = checks + 2;
		if (mem_model.exists(console_probe)) begin
			errors = errors + 1;
			$display("%s: console write reached memory during the download", case_name[idx]);
		end
		if (!case_err[idx] && stall_cycles == 0) begin
			errors = errors + 1;
			$display("%s: dl_wait never held back the source", case_name[idx]);
		end
		// Replay the payload from the same LCG start
		s = seed_start;
		for (int k = 0; k < prg_bytes; k++) begin
			s = lcg_step(s);
			verify_byte(case_name[idx], k, s[23:16]);
		end
		for (int k = 0; k < chr_bytes; k++) begin
			s = lcg_step(s);
			verify_byte(case_name[idx], chr_base + k, s[23:16]);
		end
	endtask

	initial begin
		reset_nes        = 1'b1;
		dl_active        = 1'b0;
		dl_wr            = 1'b0;
		dl_data          = 8'h00;
		invert_mirroring = 1'b0;
		cpu_addr         = '0;
		cpu_read         = 1'b0;
		cpu_write        = 1'b0;
		cpu_wdata        = 8'h00;
		mem_rdata        = 8'h00;
		write_count      = 0;
		dup_writes       = 0;
		stall_cycles     = 0;
		lcg_state        = 32'h2ed8_1831;
		fill_table();
		table_ready = 1'b1;
		apply_reset();
		check_reset_state("reset");
		console_idle_test();
		for (int i = 0; i < n_cases; i++)
			run_case(i);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog, 16 cycles per streamed byte plus margin per case
	initial begin
		longint limit_cycles;
		wait (table_ready);
		limit_cycles = 2000;
		for (int i = 0; i < n_cases; i++)
			limit_cycles = limit_cycles + 16 * stream_length(i) + 200;
		#(limit_cycles * period);
		$display("Timeout: run still going after %0d cycles", limit_cycles);
		$display("Checks run: %0d, errors: %0d", checks, errors + 1);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: nes_cart_loader.f
nes_cart_pkg.sv
mem_bus_if.sv
game_loader.sv
loader_write_buffer.sv
mem_arbiter.sv
nes_cart_loader.sv
tb_nes_cart_loader.sv
